// ==== logic/cmd_pkg.sv ====
package cmd_pkg;

    // Bus and memory geometry
    localparam int bus_abits = 16;
    localparam int mem_abits = 10;

    localparam logic [7:0] cmd_version = 8'd1;

    localparam logic [bus_abits-1:0] reg_space = 16'd16;    // First memory address
    localparam logic [bus_abits-1:0] mem_depth = bus_abits'(1 << mem_abits);

    // Register map
    localparam logic [bus_abits-1:0] addr_ctrl    = 16'd0;  // Version / soft reset
    localparam logic [bus_abits-1:0] addr_status  = 16'd1;  // Status / start
    localparam logic [bus_abits-1:0] addr_size_lo = 16'd2;
    localparam logic [bus_abits-1:0] addr_size_hi = 16'd3;
    localparam logic [bus_abits-1:0] addr_rep_lo  = 16'd4;
    localparam logic [bus_abits-1:0] addr_rep_hi  = 16'd5;
    localparam logic [bus_abits-1:0] addr_mem_lo  = 16'd6;  // Memory size, read only
    localparam logic [bus_abits-1:0] addr_mem_hi  = 16'd7;

    // Idle fill, low half 7E goes out first
    localparam logic [15:0] sync_pattern = 16'h817E;

    typedef enum logic [1:0] {
        seq_off,
        seq_sync,
        seq_data
    } seq_state_t;

endpackage

// ==== logic/cmd_regs.sv ====
module cmd_regs (
    input  logic                          BUS_CLK,
    input  logic                          RST,
    input  logic [cmd_pkg::bus_abits-1:0] BUS_ADD,
    input  logic [7:0]                    BUS_DATA_IN,
    input  logic                          BUS_WR,
    input  logic                          BUS_RD,
    output logic [7:0]                    BUS_DATA_OUT,
    input  logic [7:0]                    mem_rdata,
    input  logic                          busy,
    input  logic                          running,
    output logic                          start,
    output logic                          soft_rst,
    output logic [15:0]                   seq_size,
    output logic [15:0]                   seq_repeat,
    output logic                          mem_we
);
    import cmd_pkg::*;

    logic       in_mem;     // Address falls in the command memory
    logic       mem_sel;    // Last read went to memory
    logic [7:0] reg_rdata;

    assign in_mem = (BUS_ADD >= reg_space) && (BUS_ADD < reg_space + mem_depth);
    assign mem_we = BUS_WR && in_mem;
    assign start  = BUS_WR && (BUS_ADD == addr_status);

    // Soft reset takes effect one cycle after the write
    always_ff @(posedge BUS_CLK) begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= BUS_WR && (BUS_ADD == addr_ctrl);
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            seq_size   <= 16'd0;
            seq_repeat <= 16'd1;    // One pass by default
        end else if (BUS_WR) begin
            case (BUS_ADD)
                addr_size_lo: seq_size[7:0]    <= BUS_DATA_IN;
                addr_size_hi: seq_size[15:8]   <= BUS_DATA_IN;
                addr_rep_lo:  seq_repeat[7:0]  <= BUS_DATA_IN;
                addr_rep_hi:  seq_repeat[15:8] <= BUS_DATA_IN;
                default:      ;
            endcase
        end
    end

    // Register reads, zero when idle or unmapped
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            reg_rdata <= 8'h00;
            mem_sel   <= 1'b0;
        end else begin
            mem_sel <= BUS_RD && in_mem;
            if (BUS_RD) begin
                case (BUS_ADD)
                    addr_ctrl:    reg_rdata <= cmd_version;
                    addr_status:  reg_rdata <= {6'b0, running, !busy};
                    addr_size_lo: reg_rdata <= seq_size[7:0];
                    addr_size_hi: reg_rdata <= seq_size[15:8];
                    addr_rep_lo:  reg_rdata <= seq_repeat[7:0];
                    addr_rep_hi:  reg_rdata <= seq_repeat[15:8];
                    addr_mem_lo:  reg_rdata <= mem_depth[7:0];
                    addr_mem_hi:  reg_rdata <= mem_depth[15:8];
                    default:      reg_rdata <= 8'h00;
                endcase
            end else begin
                reg_rdata <= 8'h00;
            end
        end
    end

    assign BUS_DATA_OUT = mem_sel ? mem_rdata : reg_rdata;

    // Host issues one access per cycle
    a_no_rd_wr: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(BUS_WR && BUS_RD));

endmodule

// ==== logic/cmd_mem.sv ====
module cmd_mem (
    input  logic                          BUS_CLK,
    input  logic                          we,
    input  logic [cmd_pkg::mem_abits-1:0] wr_addr,
    input  logic [7:0]                    wdata,
    input  logic [cmd_pkg::mem_abits-1:0] bus_addr,
    output logic [7:0]                    bus_rdata,
    input  logic [cmd_pkg::mem_abits-1:0] rd_addr,
    output logic [7:0]                    rd_data
);
    import cmd_pkg::*;

    logic [7:0]           mem_q [mem_depth];
    logic [mem_abits-1:0] wr_idx;
    logic [mem_abits-1:0] bus_idx;

    // Bus addresses start at reg_space, wraps cleanly modulo the depth
    assign wr_idx  = wr_addr - reg_space[mem_abits-1:0];
    assign bus_idx = bus_addr - reg_space[mem_abits-1:0];

    always_ff @(posedge BUS_CLK) begin
        if (we)
            mem_q[wr_idx] <= wdata;
    end

    // One cycle bus read latency
    always_ff @(posedge BUS_CLK) begin
        bus_rdata <= mem_q[bus_idx];
    end

    // Sequencer side, byte ready in the request cycle
    assign rd_data = mem_q[rd_addr];

endmodule

// ==== logic/cmd_sequencer.sv ====
module cmd_sequencer (
    input  logic                          BUS_CLK,
    input  logic                          RST,
    input  logic                          soft_rst,
    input  logic                          start,
    input  logic [15:0]                   seq_size,
    input  logic [15:0]                   seq_repeat,
    input  logic                          next_byte,
    input  logic [7:0]                    rd_data,
    output logic [cmd_pkg::mem_abits-1:0] rd_addr,
    output logic [7:0]                    byte_in,
    output logic                          busy,
    output logic                          running
);
    import cmd_pkg::*;

    seq_state_t  state;
    logic        half_hi;   // Next sync byte is 81
    logic        pending;   // Run requested, waiting for pair boundary
    logic [15:0] pass_cnt;
    logic [15:0] addr_ext;
    logic        last_addr;
    logic        last_pass;

    assign addr_ext  = 16'(rd_addr);
    assign last_addr = (addr_ext == seq_size - 16'd1);
    assign last_pass = (pass_cnt == seq_repeat - 16'd1);

    assign running = (state != seq_off);
    assign busy    = pending || (state == seq_data);

    always_comb begin
        if (state == seq_data)
            byte_in = rd_data;
        else if (half_hi)
            byte_in = sync_pattern[15:8];
        else
            byte_in = sync_pattern[7:0];
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            state    <= seq_off;
            half_hi  <= 1'b0;
            pending  <= 1'b0;
            rd_addr  <= '0;
            pass_cnt <= 16'd0;
        end else begin
            // Empty runs only start the sync stream
            if (start && !busy && seq_size != 16'd0 && seq_repeat != 16'd0)
                pending <= 1'b1;

            case (state)
                seq_off: begin
                    if (start)
                        state <= seq_sync;
                end
                seq_sync: begin
                    if (next_byte) begin
                        half_hi <= !half_hi;
                        // Switch only after the 81 half has been loaded
                        if (half_hi && pending) begin
                            state   <= seq_data;
                            pending <= 1'b0;
                        end
                    end
                end
                seq_data: begin
                    if (next_byte) begin
                        if (last_addr) begin
                            rd_addr <= '0;
                            if (last_pass) begin
                                pass_cnt <= 16'd0;
                                state    <= seq_sync;   // Resumes with 7E
                            end else begin
                                pass_cnt <= pass_cnt + 16'd1;
                            end
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                default: state <= seq_off;
            endcase
        end
    end

    a_addr_in_range: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        (state == seq_data) |-> (addr_ext < seq_size));

    a_pass_bound: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        pass_cnt <= seq_repeat);

endmodule

// ==== logic/cmd_serializer.sv ====
module cmd_serializer (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       soft_rst,
    input  logic       enable,
    input  logic [7:0] byte_in,
    output logic       next_byte,
    output logic       cmd_serial_out,
    output logic [7:0] cmd_byte,
    output logic       cmd_byte_valid
);
    logic [2:0] slot_cnt;
    logic [7:0] shift_q;
    logic [6:0] valid_hist;    // Last 7 cycles of cmd_byte_valid

    // Request at the start of every 8-cycle slot
    assign next_byte      = enable && (slot_cnt == 3'd0);
    assign cmd_serial_out = shift_q[0];     // LSB first

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_rst) begin
            slot_cnt       <= 3'd0;
            shift_q        <= 8'h00;
            cmd_byte_valid <= 1'b0;
            valid_hist     <= 7'd0;
        end else begin
            if (enable)
                slot_cnt <= slot_cnt + 3'd1;    // Wraps every 8
            else
                slot_cnt <= 3'd0;

            if (next_byte)
                shift_q <= byte_in;
            else
                shift_q <= {1'b0, shift_q[7:1]};

            cmd_byte_valid <= next_byte;
            valid_hist     <= {valid_hist[5:0], cmd_byte_valid};
        end
    end

    // Monitor copy of the byte now on the line
    always_ff @(posedge BUS_CLK) begin
        if (next_byte)
            cmd_byte <= byte_in;
    end

    a_valid_gap: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        cmd_byte_valid |-> (valid_hist == 7'd0));

endmodule

// ==== logic/cmd_top.sv ====
module cmd_top (
    input  logic                          BUS_CLK,
    input  logic                          RST,
    input  logic [cmd_pkg::bus_abits-1:0] BUS_ADD,
    input  logic [7:0]                    BUS_DATA_IN,
    input  logic                          BUS_WR,
    input  logic                          BUS_RD,
    output logic [7:0]                    BUS_DATA_OUT,
    output logic                          cmd_serial_out,
    output logic [7:0]                    cmd_byte,
    output logic                          cmd_byte_valid
);
    import cmd_pkg::*;

    logic                 start;
    logic                 soft_rst;
    logic [15:0]          seq_size;
    logic [15:0]          seq_repeat;
    logic                 busy;
    logic                 running;
    logic                 mem_we;
    logic [7:0]           mem_rdata;
    logic [mem_abits-1:0] rd_addr;
    logic [7:0]           rd_data;
    logic                 next_byte;
    logic [7:0]           byte_in;

    cmd_regs i_cmd_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_WR       (BUS_WR),
        .BUS_RD       (BUS_RD),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .mem_rdata    (mem_rdata),
        .busy         (busy),
        .running      (running),
        .start        (start),
        .soft_rst     (soft_rst),
        .seq_size     (seq_size),
        .seq_repeat   (seq_repeat),
        .mem_we       (mem_we)
    );

    // Memory strips the register offset itself
    cmd_mem i_cmd_mem (
        .BUS_CLK   (BUS_CLK),
        .we        (mem_we),
        .wr_addr   (BUS_ADD[mem_abits-1:0]),
        .wdata     (BUS_DATA_IN),
        .bus_addr  (BUS_ADD[mem_abits-1:0]),
        .bus_rdata (mem_rdata),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    cmd_sequencer i_cmd_sequencer (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .soft_rst   (soft_rst),
        .start      (start),
        .seq_size   (seq_size),
        .seq_repeat (seq_repeat),
        .next_byte  (next_byte),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .byte_in    (byte_in),
        .busy       (busy),
        .running    (running)
    );

    cmd_serializer i_cmd_serializer (
        .BUS_CLK        (BUS_CLK),
        .RST            (RST),
        .soft_rst       (soft_rst),
        .enable         (running),
        .byte_in        (byte_in),
        .next_byte      (next_byte),
        .cmd_serial_out (cmd_serial_out),
        .cmd_byte       (cmd_byte),
        .cmd_byte_valid (cmd_byte_valid)
    );

endmodule

// ==== verif/cmd_tb.sv ====
module cmd_tb;
    import cmd_pkg::*;

    typedef struct packed {
        int len;
        int rep;
        int n_data;     // Expected data bytes, len times rep
        bit restart;    // Extra start while busy
    } run_t;

    run_t runs [6] = '{
        '{4, 1, 4, 1'b0}, '{3, 3, 9, 1'b0}, '{1, 5, 5, 1'b0},
        '{16, 2, 32, 1'b1}, '{0, 3, 0, 1'b0}, '{5, 0, 0, 1'b0}
    };

    logic        BUS_CLK = 1'b0;
    logic        RST = 1'b1;
    logic [15:0] BUS_ADD = 16'h0000;
    logic [7:0]  BUS_DATA_IN = 8'h00;
    logic        BUS_WR = 1'b0;
    logic        BUS_RD = 1'b0;
    logic [7:0]  BUS_DATA_OUT;
    logic        cmd_serial_out;
    logic [7:0]  cmd_byte;
    logic        cmd_byte_valid;

    logic [7:0]  mem_img [16];      // Memory bytes 0 to 15
    logic [7:0]  stream [$];        // Bytes seen on cmd_byte
    logic [15:0] lfsr = 16'd60;
    logic [7:0]  rx_byte;
    logic [7:0]  exp_byte;
    bit          have_prev;
    bit          mon_hold;          // Soft reset cuts the byte on the line
    int          cyc;
    int          last_cyc;
    int          nbits = 8;
    int          errors;
    int          serial_err;
    int          tests;
    int          tests_failed;

    cmd_top i_cmd_top (.*);

    always #2 BUS_CLK = ~BUS_CLK;

    // Fibonacci LFSR with taps 16 14 13 11, one step per bit taken
    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] r;
        int i;
        r = 16'h0000;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // Optional leading 81, whole sync pairs, the data passes, then sync from 7E
    function automatic bit stream_ok(int len, int n_data);
        int s0;
        int p;
        int i;
        bit ok;
        s0 = (stream.size() > 0 && stream[0] == 8'h81) ? 1 : 0;
        for (p = s0; p + n_data < stream.size(); p += 2) begin
            ok = 1'b1;
            for (i = s0; i < p; i++)
                if (stream[i] != (((i - s0) % 2) != 0 ? 8'h81 : 8'h7E))
                    ok = 1'b0;
            for (i = 0; i < n_data; i++)
                if (stream[p + i] != mem_img[i % len])
                    ok = 1'b0;
            for (i = p + n_data; i < stream.size(); i++)
                if (stream[i] != (((i - p - n_data) % 2) != 0 ? 8'h81 : 8'h7E))
                    ok = 1'b0;
            if (ok)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic bus_write(logic [15:0] addr, logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD     <= addr;
        BUS_DATA_IN <= data;
        BUS_WR      <= 1'b1;
        @(posedge BUS_CLK);
        BUS_WR <= 1'b0;
    endtask

    task automatic bus_read(logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        BUS_ADD <= addr;
        BUS_RD  <= 1'b1;
        @(posedge BUS_CLK);
        BUS_RD <= 1'b0;
        @(negedge BUS_CLK);     // Read data lives for this one cycle
        data = BUS_DATA_OUT;
    endtask

    task automatic check_read(logic [15:0] addr, logic [7:0] exp, string name);
        logic [7:0] got;
        bus_read(addr, got);
        assert (got === exp) else begin
            $display("[FAIL] BUS_DATA_OUT (%s) at %h: got %h, expected %h",
                     name, addr, got, exp);
            errors++;
        end
    endtask

    task automatic wait_done();
        logic [7:0] st;
        int t0;
        t0 = cyc;
        st = 8'h00;
        while (!st[0] && cyc - t0 < 4000)
            bus_read(addr_status, st);
        assert (st[0]) else begin
            $display("Timeout: status never showed done within 4000 cycles");
            errors++;
        end
    endtask

    task automatic wait_bytes(int n);
        int t0;
        t0 = cyc;
        while (stream.size() < n && cyc - t0 < 4000)
            @(posedge BUS_CLK);
        assert (stream.size() >= n) else begin
            $display("Timeout: only %0d of %0d stream bytes arrived", stream.size(), n);
            errors++;
        end
    endtask

    task automatic report(string name, int fails);
        tests++;
        if (fails != 0)
            tests_failed++;
        $display("test %s: %s", name, (fails == 0) ? "ok" : "FAILED");
    endtask

    // Byte capture and serial rebuild, sampled on the falling edge
    always @(negedge BUS_CLK) begin
        cyc++;
        if (cmd_byte_valid) begin
            assert (mon_hold || !have_prev || cyc - last_cyc == 8) else begin
                $display("cmd_byte_valid pulses came %0d cycles apart", cyc - last_cyc);
                errors++;
                serial_err++;
            end
            have_prev = 1'b1;
            last_cyc  = cyc;
            exp_byte  = cmd_byte;
            nbits     = 0;
            stream.push_back(cmd_byte);
        end
        if (nbits < 8 && !mon_hold) begin
            rx_byte = {cmd_serial_out, rx_byte[7:1]};   // LSB arrives first
            nbits++;
            if (nbits == 8) begin
                assert (rx_byte == exp_byte) else begin
                    $display("[FAIL] cmd_serial_out: got %h, expected %h", rx_byte, exp_byte);
                    errors++;
                    serial_err++;
                end
            end
        end
    end

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        int          e0;
        int          k;
        int          t0;

        repeat (8) @(posedge BUS_CLK);
        RST <= 1'b0;

        e0 = errors;
        check_read(addr_ctrl, 8'h01, "version");
        check_read(addr_size_lo, 8'h00, "size_lo");
        check_read(addr_size_hi, 8'h00, "size_hi");
        check_read(addr_rep_lo, 8'h01, "repeat_lo");
        check_read(addr_rep_hi, 8'h00, "repeat_hi");
        check_read(addr_mem_lo, 8'h00, "mem_size_lo");
        check_read(addr_mem_hi, 8'h04, "mem_size_hi");
        check_read(addr_status, 8'h01, "status");
        assert (stream.size() == 0) else begin
            $display("cmd_byte_valid pulsed before the first start");
            errors++;
        end
        report("reset values", errors - e0);

        e0 = errors;
        for (k = 0; k < 16; k++) begin
            mem_img[k] = 8'(rand_bits(8));
            bus_write(reg_space + 16'(k), mem_img[k]);
        end
        for (k = 0; k < 16; k++)
            check_read(reg_space + 16'(k), mem_img[k], "mem data");
        for (k = 0; k < 8; k++) begin
            addr = reg_space + (rand_bits(10) | 16'h0010);    // Clear of the run bytes
            data = 8'(rand_bits(8));
            bus_write(addr, data);
            check_read(addr, data, "mem data");
        end
        check_read(16'd8, 8'h00, "unmapped");
        check_read(16'd15, 8'h00, "unmapped");
        check_read(reg_space + mem_depth, 8'h00, "above memory");
        report("memory access", errors - e0);

        for (k = 0; k < 6; k++) begin
            e0 = errors;
            bus_write(addr_size_lo, 8'(runs[k].len));
            bus_write(addr_size_hi, 8'(runs[k].len >> 8));
            bus_write(addr_rep_lo, 8'(runs[k].rep));
            bus_write(addr_rep_hi, 8'(runs[k].rep >> 8));
            bus_write(addr_status, 8'h00);
            stream.delete();
            check_read(addr_status, {6'b0, 1'b1, runs[k].n_data == 0}, "status after start");
            if (runs[k].restart) begin
                repeat (40) @(posedge BUS_CLK);
                bus_write(addr_status, 8'h00);      // Ignored while busy
            end
            wait_done();
            wait_bytes(stream.size() + 3);
            assert (stream_ok(runs[k].len, runs[k].n_data)) else begin
                $display("Stream is not sync pairs, %0d data bytes, sync", runs[k].n_data);
                errors++;
            end
            report($sformatf("run %0d x %0d", runs[k].len, runs[k].rep), errors - e0);
        end
        report("serial line", serial_err);

        e0 = errors;
        bus_write(addr_size_lo, 8'd16);
        bus_write(addr_rep_lo, 8'd2);
        bus_write(addr_status, 8'h00);
        stream.delete();
        wait_bytes(8);
        mon_hold = 1'b1;
        bus_write(addr_ctrl, 8'h00);
        t0 = cyc;
        repeat (24) @(posedge BUS_CLK);
        assert (last_cyc - t0 <= 9) else begin
            $display("cmd_byte_valid still pulsed %0d cycles after soft reset", last_cyc - t0);
            errors++;
        end
        check_read(addr_status, 8'h01, "status");
        check_read(addr_size_lo, 8'h00, "size_lo");
        check_read(addr_size_hi, 8'h00, "size_hi");
        check_read(addr_rep_lo, 8'h01, "repeat_lo");
        check_read(addr_rep_hi, 8'h00, "repeat_hi");
        report("soft reset", errors - e0);

        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== all.f ====
logic/cmd_pkg.sv
logic/cmd_regs.sv
logic/cmd_mem.sv
logic/cmd_sequencer.sv
logic/cmd_serializer.sv
logic/cmd_top.sv
verif/cmd_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module cmd_tb -f all.f
	out="$$(./obj_dir/Vcmd_tb)"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
